// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tbOperandModifiers
FILELIST  = vlog.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and fail unless the run passes"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== src/ComponentModifier.sv ====
`include "operandModifier_defines.svh"

module ComponentModifier (
  input  operandModifierPkg::rowT    row,
  input  operandModifierPkg::srcTagT tag,
  input  logic                       scaleDown,
  output operandModifierPkg::rowT    result
);

  operandModifierPkg::componentT  inX, inY, inZ;
  operandModifierPkg::componentT  signX, signY, signZ;
  operandModifierPkg::componentT  scaledX, scaledY, scaledZ;
  operandModifierPkg::componentT  outX, outY, outZ;
  operandModifierPkg::swizzleSelT selX, selY, selZ;

  assign inX = row[`ROW_WIDTH-1 -: `COMPONENT_WIDTH];
  assign inY = row[2*`COMPONENT_WIDTH-1 -: `COMPONENT_WIDTH];
  assign inZ = row[`COMPONENT_WIDTH-1:0];

  // Sign flip per component
  assign signX = tag[`TAG_SIGN_X] ? -inX : inX;
  assign signY = tag[`TAG_SIGN_Y] ? -inY : inY;
  assign signZ = tag[`TAG_SIGN_Z] ? -inZ : inZ;

  assign scaledX = scaleDown ? (signX >>> `SCALE_SHIFT) : signX;  // Keeps the sign
  assign scaledY = scaleDown ? (signY >>> `SCALE_SHIFT) : signY;
  assign scaledZ = scaleDown ? (signZ >>> `SCALE_SHIFT) : signZ;

  // ------------------------------------------------------------
  // Swizzle
  // ------------------------------------------------------------
  assign selX = operandModifierPkg::swizzleSelT'(tag[1:0]);
  assign selY = operandModifierPkg::swizzleSelT'(tag[3:2]);
  assign selZ = operandModifierPkg::swizzleSelT'(tag[5:4]);

  always_comb begin
    outX = '0;
    outY = '0;
    outZ = '0;
    case (selX)
      operandModifierPkg::swizzleKeep:   outX = scaledX;
      operandModifierPkg::swizzleFirst:  outX = scaledZ;
      operandModifierPkg::swizzleSecond: outX = scaledY;
      operandModifierPkg::swizzleZero:   outX = '0;
    endcase
    case (selY)
      operandModifierPkg::swizzleKeep:   outY = scaledY;
      operandModifierPkg::swizzleFirst:  outY = scaledZ;
      operandModifierPkg::swizzleSecond: outY = scaledX;
      operandModifierPkg::swizzleZero:   outY = '0;
    endcase
    case (selZ)
      operandModifierPkg::swizzleKeep:   outZ = scaledZ;
      operandModifierPkg::swizzleFirst:  outZ = scaledY;
      operandModifierPkg::swizzleSecond: outZ = scaledX;
      operandModifierPkg::swizzleZero:   outZ = '0;
    endcase
  end

  assign result = {outX, outY, outZ};

endmodule

// ==== src/OperandModifiers.sv ====
`include "operandModifier_defines.svh"

module OperandModifiers (
  input  logic                       Clock,
  input  logic                       reset,
  input  operandModifierPkg::rsIdT   issueRsId,
  input  operandModifierPkg::rsIdT   src0Rs,
  input  operandModifierPkg::rsIdT   src1Rs,
  input  operandModifierPkg::srcTagT src0Tag,
  input  operandModifierPkg::srcTagT src1Tag,
  input  operandModifierPkg::rowT    src0Data,
  input  operandModifierPkg::rowT    src1Data,
  input  logic                       scale0Down,
  input  logic                       scale1Down,
  input  operandModifierPkg::rsIdT   commitRsId,
  input  operandModifierPkg::rowT    commitData,
  output operandModifierPkg::rowT    src0Operand,
  output operandModifierPkg::rowT    src1Operand,
  output logic [`STATION_COUNT-1:0]  stationBusy,
  output logic                       modCommitValid,
  output operandModifierPkg::rsIdT   modCommitRsId,
  output operandModifierPkg::rowT    modCommitData
);

  logic                       issueActive;
  logic [`STATION_COUNT-1:0]  dependent;
  logic [`STATION_COUNT-1:0]  capture;
  logic [`STATION_COUNT-1:0]  request;
  logic [`STATION_COUNT-1:0]  grant;
  logic [`STATION_COUNT-1:0]  srcScale;
  logic [`STATION_COUNT-1:0]  stationScale;
  operandModifierPkg::rsIdT   srcRs        [`STATION_COUNT];
  operandModifierPkg::srcTagT srcTag       [`STATION_COUNT];
  operandModifierPkg::rsIdT   stationRs    [`STATION_COUNT];
  operandModifierPkg::srcTagT stationTag   [`STATION_COUNT];
  operandModifierPkg::rowT    stationData  [`STATION_COUNT];
  operandModifierPkg::rowT    sharedRow;
  operandModifierPkg::srcTagT sharedTag;
  logic                       sharedScale;
  operandModifierPkg::rowT    sharedResult;
  operandModifierPkg::rowT    src1Result;

  assign issueActive = (issueRsId != '0);  // Any nonzero id is an issue

  // Source k always parks in station k
  assign srcRs[0]    = src0Rs;
  assign srcRs[1]    = src1Rs;
  assign srcTag[0]   = src0Tag;
  assign srcTag[1]   = src1Tag;
  assign srcScale[0] = scale0Down;
  assign srcScale[1] = scale1Down;

  // ------------------------------------------------------------
  // Wait stations
  // ------------------------------------------------------------
  for (genvar k = 0; k < `STATION_COUNT; k++) begin : gStation
    assign dependent[k] = (srcRs[k] != '0);
    // An issue onto a busy station is dropped, the issuer stalls on stationBusy
    assign capture[k] = issueActive & dependent[k] & ~stationBusy[k];

    OperandStation station (
      .Clock        (Clock),
      .reset        (reset),
      .capture      (capture[k]),
      .captureRs    (srcRs[k]),
      .captureTag   (srcTag[k]),
      .captureScale (srcScale[k]),
      .commitRsId   (commitRsId),
      .commitData   (commitData),
      .grant        (grant[k]),
      .busy         (stationBusy[k]),
      .request      (request[k]),
      .rsId         (stationRs[k]),
      .tag          (stationTag[k]),
      .scaleDown    (stationScale[k]),
      .data         (stationData[k])
    );
  end

  ReplayArbiter arbiter (
    .Clock       (Clock),
    .reset       (reset),
    .issueActive (issueActive),
    .request     (request),
    .grant       (grant)
  );

  // ------------------------------------------------------------
  // Shared source-0 modifier
  // ------------------------------------------------------------
  // Grant is never given during an issue, so it alone picks the input
  always_comb begin
    sharedRow     = src0Data;
    sharedTag     = src0Tag;
    sharedScale   = scale0Down;
    modCommitRsId = '0;
    for (int i = 0; i < `STATION_COUNT; i++) begin
      if (grant[i]) begin
        sharedRow     = stationData[i];
        sharedTag     = stationTag[i];
        sharedScale   = stationScale[i];
        modCommitRsId = stationRs[i];  // The id the station waited for
      end
    end
  end

  ComponentModifier sharedModifier (
    .row       (sharedRow),
    .tag       (sharedTag),
    .scaleDown (sharedScale),
    .result    (sharedResult)
  );

  ComponentModifier src1Modifier (  // Issue path only
    .row       (src1Data),
    .tag       (src1Tag),
    .scaleDown (scale1Down),
    .result    (src1Result)
  );

  // Dependent operands carry their tag instead of a value
  assign src0Operand = dependent[0] ?
    {{(`ROW_WIDTH-`SRC_TAG_WIDTH){1'b0}}, src0Tag} : sharedResult;
  assign src1Operand = dependent[1] ?
    {{(`ROW_WIDTH-`SRC_TAG_WIDTH){1'b0}}, src1Tag} : src1Result;

  assign modCommitValid = |grant;
  assign modCommitData  = sharedResult;

endmodule

// ==== src/OperandStation.sv ====
module OperandStation (
  input  logic                       Clock,
  input  logic                       reset,
  input  logic                       capture,
  input  operandModifierPkg::rsIdT   captureRs,
  input  operandModifierPkg::srcTagT captureTag,
  input  logic                       captureScale,
  input  operandModifierPkg::rsIdT   commitRsId,
  input  operandModifierPkg::rowT    commitData,
  input  logic                       grant,
  output logic                       busy,
  output logic                       request,
  output operandModifierPkg::rsIdT   rsId,
  output operandModifierPkg::srcTagT tag,
  output logic                       scaleDown,
  output operandModifierPkg::rowT    data
);

  logic match;

  // Data is held stable once a replay is requested
  assign match = busy && !request && (commitRsId == rsId);

  // ------------------------------------------------------------
  // Station state
  // ------------------------------------------------------------
  always_ff @(posedge Clock) begin
    if (reset) begin
      busy    <= 1'b0;
      request <= 1'b0;
    end else if (grant) begin
      busy    <= 1'b0;  // Replay done, station free again
      request <= 1'b0;
    end else begin
      if (capture) begin
        busy <= 1'b1;
      end
      if (match) begin
        request <= 1'b1;
      end
    end
  end

  // Modifier settings and awaited result
  always_ff @(posedge Clock) begin
    if (capture) begin
      rsId      <= captureRs;
      tag       <= captureTag;
      scaleDown <= captureScale;
    end
    if (match) begin
      data <= commitData;
    end
  end

endmodule

// ==== src/ReplayArbiter.sv ====
`include "operandModifier_defines.svh"

module ReplayArbiter (
  input  logic                      Clock,
  input  logic                      reset,
  input  logic                      issueActive,
  input  logic [`STATION_COUNT-1:0] request,
  output logic [`STATION_COUNT-1:0] grant
);

  operandModifierPkg::arbTurnT turn;

  // Issue owns the shared modifier, replays only fill idle cycles
  always_comb begin
    grant = '0;
    if (!issueActive) begin
      if (turn == operandModifierPkg::turnStation0) begin
        if (request[0]) grant[0] = 1'b1;
        else if (request[1]) grant[1] = 1'b1;
      end else begin
        if (request[1]) grant[1] = 1'b1;
        else if (request[0]) grant[0] = 1'b1;
      end
    end
  end

  // Turn passes to the station that was not served
  always_ff @(posedge Clock) begin
    if (reset) begin
      turn <= operandModifierPkg::turnStation0;
    end else if (grant[0]) begin
      turn <= operandModifierPkg::turnStation1;
    end else if (grant[1]) begin
      turn <= operandModifierPkg::turnStation0;
    end
  end

endmodule

// ==== src/operandModifierPkg.sv ====
`include "operandModifier_defines.svh"

package operandModifierPkg;

  typedef logic signed [`COMPONENT_WIDTH-1:0] componentT;
  typedef logic [`ROW_WIDTH-1:0]              rowT;      // X high, Z low
  typedef logic [`SRC_TAG_WIDTH-1:0]          srcTagT;
  typedef logic [`RS_ID_WIDTH-1:0]            rsIdT;     // Zero means none

  // Per-component swizzle select, two bits each in the tag
  typedef enum logic [1:0] {
    swizzleKeep   = 2'd0,
    swizzleFirst  = 2'd1,
    swizzleSecond = 2'd2,
    swizzleZero   = 2'd3
  } swizzleSelT;

  // Round-robin turn of the replay arbiter
  typedef enum logic {
    turnStation0 = 1'b0,
    turnStation1 = 1'b1
  } arbTurnT;

endpackage

// ==== src/operandModifier_defines.svh ====
`ifndef OPERAND_MODIFIER_DEFINES_SVH
`define OPERAND_MODIFIER_DEFINES_SVH

// ------------------------------------------------------------
// Row format
// ------------------------------------------------------------
`define COMPONENT_WIDTH 32  // One vector component
`define ROW_WIDTH       96  // X, Y and Z
`define SRC_TAG_WIDTH   9   // Swizzle selects plus sign bits
`define RS_ID_WIDTH     4   // Zero means no station

// Sign bits inside the source tag
`define TAG_SIGN_X 6
`define TAG_SIGN_Y 7
`define TAG_SIGN_Z 8

`define SCALE_SHIFT   8  // Arithmetic down-scale amount
`define STATION_COUNT 2  // One wait station per source

`endif

// ==== tb/tbOperandModifiers.sv ====
`include "operandModifier_defines.svh"

module tbOperandModifiers;

  logic                       Clock;
  logic                       reset;
  operandModifierPkg::rsIdT   issueRsId;
  operandModifierPkg::rsIdT   src0Rs;
  operandModifierPkg::rsIdT   src1Rs;
  operandModifierPkg::srcTagT src0Tag;
  operandModifierPkg::srcTagT src1Tag;
  operandModifierPkg::rowT    src0Data;
  operandModifierPkg::rowT    src1Data;
  logic                       scale0Down;
  logic                       scale1Down;
  operandModifierPkg::rsIdT   commitRsId;
  operandModifierPkg::rowT    commitData;
  operandModifierPkg::rowT    src0Operand;
  operandModifierPkg::rowT    src1Operand;
  logic [`STATION_COUNT-1:0]  stationBusy;
  logic                       modCommitValid;
  operandModifierPkg::rsIdT   modCommitRsId;
  operandModifierPkg::rowT    modCommitData;

  logic [31:0]                lfsrState;
  int                         errorCount;
  int                         timeoutCount;
  logic                       checkOperands;   // Arms the operand compare process
  operandModifierPkg::rowT    expect0;
  operandModifierPkg::rowT    expect1;

  OperandModifiers DUT (.*);

  initial begin
    Clock = 1'b0;
    forever #5 Clock = ~Clock;
  end

  // ------------------------------------------------------------
  // Stimulus and reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hD0000001) : (state >> 1);
  endfunction

  // One LFSR step per bit taken, LSB of the state is the new bit
  function automatic operandModifierPkg::rowT randomBits(input int width);
    operandModifierPkg::rowT value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[`ROW_WIDTH-2:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic operandModifierPkg::rowT modelRow(input operandModifierPkg::rowT row,
                                                       input operandModifierPkg::srcTagT tag,
                                                       input logic scaleDown);
    operandModifierPkg::componentT c [3];
    operandModifierPkg::componentT o [3];
    logic [1:0]                    sel;
    for (int i = 0; i < 3; i++) begin  // Index 0 is X
      c[i] = row[(2-i)*`COMPONENT_WIDTH +: `COMPONENT_WIDTH];
      if (tag[`TAG_SIGN_X + i]) c[i] = -c[i];
      if (scaleDown) c[i] = c[i] >>> `SCALE_SHIFT;
    end
    for (int i = 0; i < 3; i++) begin
      sel = tag[2*i +: 2];
      case (sel)
        2'd0:    o[i] = c[i];
        2'd1:    o[i] = (i == 2) ? c[1] : c[2];  // Z for X and Y, Y for Z
        2'd2:    o[i] = (i == 0) ? c[1] : c[0];  // Y for X, X otherwise
        default: o[i] = '0;
      endcase
    end
    return {o[0], o[1], o[2]};
  endfunction

  task automatic checkRow(input string name, input operandModifierPkg::rowT expected,
                          input operandModifierPkg::rowT actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkRsId(input string name, input operandModifierPkg::rsIdT expected,
                           input operandModifierPkg::rsIdT actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %b, actual %b", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic clearInputs();
    issueRsId  = '0;
    src0Rs     = '0;
    src1Rs     = '0;
    src0Tag    = '0;
    src1Tag    = '0;
    src0Data   = '0;
    src1Data   = '0;
    scale0Down = 1'b0;
    scale1Down = 1'b0;
    commitRsId = '0;
    commitData = '0;
  endtask

  task automatic resetDut();
    reset = 1'b1;
    repeat (4) @(negedge Clock);
    reset = 1'b0;
  endtask

  // Called on a falling edge, looks at the current cycle first
  task automatic waitModCommit(input string name, output logic seen);
    int cycles;
    cycles = 0;
    #1;
    while (!modCommitValid && cycles < 20) begin
      @(negedge Clock);
      #1;
      cycles++;
    end
    seen = modCommitValid;
    if (!seen) begin
      $display("Timeout: %s saw no modified commit within 20 cycles", name);
      timeoutCount++;
    end
  endtask

  // Operand compare, late in the low phase
  initial begin
    forever begin
      @(negedge Clock);
      #4;
      if (checkOperands) begin
        checkRow("src0Operand", expect0, src0Operand);
        checkRow("src1Operand", expect1, src1Operand);
      end
    end
  end

  // ------------------------------------------------------------
  // Behaviors
  // ------------------------------------------------------------
  initial begin
    operandModifierPkg::srcTagT tag0;
    operandModifierPkg::srcTagT tag1;
    operandModifierPkg::rowT    commitRow;
    logic                       scale0;
    logic                       scale1;
    logic                       seen;
    errorCount    = 0;
    timeoutCount  = 0;
    lfsrState     = 32'h8615;
    checkOperands = 1'b0;
    reset         = 1'b1;
    clearInputs();
    resetDut();

    #1 checkBit("busy0 after reset", 1'b0, stationBusy[0]);
    checkBit("busy1 after reset", 1'b0, stationBusy[1]);
    checkBit("valid after reset", 1'b0, modCommitValid);

    repeat (20) begin  // Independent issues
      @(negedge Clock);
      issueRsId  = operandModifierPkg::rsIdT'(randomBits(`RS_ID_WIDTH)) | 4'd1;
      src0Tag    = operandModifierPkg::srcTagT'(randomBits(`SRC_TAG_WIDTH));
      src1Tag    = operandModifierPkg::srcTagT'(randomBits(`SRC_TAG_WIDTH));
      src0Data   = randomBits(`ROW_WIDTH);
      src1Data   = randomBits(`ROW_WIDTH);
      scale0Down = randomBits(1) != '0;
      scale1Down = randomBits(1) != '0;
      expect0    = modelRow(src0Data, src0Tag, scale0Down);
      expect1    = modelRow(src1Data, src1Tag, scale1Down);
      checkOperands = 1'b1;
    end

    @(negedge Clock);  // Dependent issue on source 0
    clearInputs();
    tag0       = operandModifierPkg::srcTagT'(randomBits(`SRC_TAG_WIDTH));
    scale0     = randomBits(1) != '0;
    issueRsId  = 4'h2;
    src0Rs     = 4'h5;
    src0Tag    = tag0;
    scale0Down = scale0;
    expect0    = operandModifierPkg::rowT'(tag0);
    expect1    = modelRow(src1Data, src1Tag, scale1Down);
    @(negedge Clock);
    checkOperands = 1'b0;
    clearInputs();
    #1 checkBit("busy0 after dependent issue", 1'b1, stationBusy[0]);
    commitRsId = 4'h3;
    commitData = randomBits(`ROW_WIDTH);
    @(negedge Clock);
    clearInputs();
    repeat (3) begin
      #1 checkBit("valid after other commit", 1'b0, modCommitValid);
      @(negedge Clock);
    end

    commitRow  = randomBits(`ROW_WIDTH);  // Matching commit
    commitRsId = 4'h5;
    commitData = commitRow;
    @(negedge Clock);
    clearInputs();
    waitModCommit("single replay", seen);
    if (seen) begin
      checkRsId("single replay id", 4'h5, modCommitRsId);
      checkRow("single replay data", modelRow(commitRow, tag0, scale0), modCommitData);
    end
    @(negedge Clock);
    #1 checkBit("busy0 after replay", 1'b0, stationBusy[0]);

    @(negedge Clock);  // Fresh turn for the ordering test
    resetDut();
    tag0       = operandModifierPkg::srcTagT'(randomBits(`SRC_TAG_WIDTH));
    tag1       = operandModifierPkg::srcTagT'(randomBits(`SRC_TAG_WIDTH));
    scale0     = randomBits(1) != '0;
    scale1     = randomBits(1) != '0;
    issueRsId  = 4'h4;
    src0Rs     = 4'h7;
    src1Rs     = 4'h7;
    src0Tag    = tag0;
    src1Tag    = tag1;
    scale0Down = scale0;
    scale1Down = scale1;
    @(negedge Clock);
    src0Rs     = '0;  // Issue stays active, no new dependency
    src1Rs     = '0;
    commitRow  = randomBits(`ROW_WIDTH);
    commitRsId = 4'h7;
    commitData = commitRow;
    #1 checkBit("busy0 both pending", 1'b1, stationBusy[0]);
    checkBit("busy1 both pending", 1'b1, stationBusy[1]);
    @(negedge Clock);
    commitRsId = '0;
    repeat (10) begin
      #1 checkBit("valid while issue held", 1'b0, modCommitValid);
      @(negedge Clock);
    end
    clearInputs();
    waitModCommit("first replay", seen);
    if (seen) begin
      checkRsId("first replay id", 4'h7, modCommitRsId);
      checkRow("first replay data", modelRow(commitRow, tag0, scale0), modCommitData);
    end
    @(negedge Clock);
    waitModCommit("second replay", seen);
    if (seen) begin
      checkRsId("second replay id", 4'h7, modCommitRsId);
      checkRow("second replay data", modelRow(commitRow, tag1, scale1), modCommitData);
    end
    @(negedge Clock);

    $display("Checks done: %0d value errors, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/operandModifierPkg.sv
src/ComponentModifier.sv
src/OperandStation.sv
src/ReplayArbiter.sv
src/OperandModifiers.sv
tb/tbOperandModifiers.sv
